// File: axiLog_consts.svh
// ******************************
// AXI logger constants
// Bus field widths, entry layout width
// and log memory geometry
// ******************************

`ifndef AXILOG_CONSTS_SVH
`define AXILOG_CONSTS_SVH

// Observed address channel fields
`define AXI_ID_W    8
`define AXI_ADDR_W  32
`define AXI_LEN_W   8

// Free-running cycle counter
`define TS_W        32

// One log entry, three readout words
`define ENTRY_W     96

// Log memory geometry
`define LOG_DEPTH   64
`define LOG_IDX_W   6

// Readout port
`define RD_DATA_W   32
// Byte address, 16 bytes per entry
`define RD_ADDR_W   (`LOG_IDX_W + 4)

`endif

// File: files.f
+incdir+.
rtl/axiLogPkg.sv
rtl/logController.sv
rtl/logMemory.sv
rtl/logReadout.sv
rtl/axiLogger.sv
testbench/axiLoggerTb.sv

// File: rtl/axiLogPkg.sv
// ******************************
// AXI logger package
// Field, entry and address types plus
// the controller state encoding
// ******************************

`default_nettype none

`include "axiLog_consts.svh"

package axiLogPkg;

  // Captured address channel fields
  typedef logic [`AXI_ID_W-1:0]   axiId_t;
  typedef logic [`AXI_ADDR_W-1:0] axiAddr_t;
  typedef logic [`AXI_LEN_W-1:0]  axiLen_t;

  // Cycles since reset or last clear, wraps at the top
  typedef logic [`TS_W-1:0] timestamp_t;

  // Entry layout, MSB first
  //   timestamp | address | zero pad | length | id
  typedef logic [`ENTRY_W-1:0] logEntry_t;

  // Slot number within the log memory
  typedef logic [`LOG_IDX_W-1:0] logIdx_t;

  // Readout byte address, word select in bits 3 and 2
  typedef logic [`RD_ADDR_W-1:0] rdAddr_t;
  typedef logic [`RD_DATA_W-1:0] rdData_t;

  // Controller state
  typedef enum logic {
    LogActive,
    LogFull
  } logState_t;

endpackage

`default_nettype wire

// File: rtl/axiLogger.sv
// ******************************
// AXI transaction logger
// Records address channel handshakes
// into an on-chip log with a 32-bit
// word readout port
// ******************************

`timescale 1ns/10ps
`default_nettype none

`include "axiLog_consts.svh"

module axiLogger (
  input  logic                Clk_CI,
  input  logic                rstN,

  // Observed address channel
  input  logic                axiValid,
  input  logic                axiReady,
  input  axiLogPkg::axiId_t   axiId,
  input  axiLogPkg::axiAddr_t axiAddr,
  input  axiLogPkg::axiLen_t  axiLen,

  // Control and status
  input  logic                clear,
  output logic                full,

  // Word readout
  input  logic                rdEn,
  input  axiLogPkg::rdAddr_t  rdAddr,
  output axiLogPkg::rdData_t  rdData,
  output logic                rdValid
);

  import axiLogPkg::*;

  // Write path
  logic      wrEn;
  logIdx_t   wrIdx;
  logEntry_t wrEntry;

  // Read path
  logic      rdEnMem;
  logIdx_t   rdIdx;
  logEntry_t memEntry;

  logController logController_inst (
    .Clk_CI   (Clk_CI),
    .rstN     (rstN),
    .axiValid (axiValid),
    .axiReady (axiReady),
    .axiId    (axiId),
    .axiAddr  (axiAddr),
    .axiLen   (axiLen),
    .clear    (clear),
    .wrEn     (wrEn),
    .wrIdx    (wrIdx),
    .wrEntry  (wrEntry),
    .full     (full)
  );

  // Contents survive clear
  logMemory logMemory_inst (
    .Clk_CI   (Clk_CI),
    .wrEn     (wrEn),
    .wrIdx    (wrIdx),
    .wrEntry  (wrEntry),
    .rdEnMem  (rdEnMem),
    .rdIdx    (rdIdx),
    .memEntry (memEntry)
  );

  logReadout logReadout_inst (
    .Clk_CI   (Clk_CI),
    .rstN     (rstN),
    .rdEn     (rdEn),
    .rdAddr   (rdAddr),
    .rdEnMem  (rdEnMem),
    .rdIdx    (rdIdx),
    .memEntry (memEntry),
    .rdData   (rdData),
    .rdValid  (rdValid)
  );

endmodule

`default_nettype wire

// File: rtl/logController.sv
// ******************************
// Log controller
// Qualifies address channel handshakes,
// builds log entries and tracks the
// slot counter, full flag and timestamp
// ******************************

`timescale 1ns/10ps
`default_nettype none

`include "axiLog_consts.svh"

module logController (
  input  logic                Clk_CI,
  input  logic                rstN,

  // Observed address channel
  input  logic                axiValid,
  input  logic                axiReady,
  input  axiLogPkg::axiId_t   axiId,
  input  axiLogPkg::axiAddr_t axiAddr,
  input  axiLogPkg::axiLen_t  axiLen,

  input  logic                clear,

  // Memory write port
  output logic                wrEn,
  output axiLogPkg::logIdx_t  wrIdx,
  output axiLogPkg::logEntry_t wrEntry,

  output logic                full
);

  import axiLogPkg::*;

  localparam logIdx_t LastIdx = logIdx_t'(`LOG_DEPTH - 1);

  // Unused entry bits between the length field and the address
  localparam int PadW = `ENTRY_W - `TS_W - `AXI_ADDR_W - `AXI_LEN_W - `AXI_ID_W;

  logState_t  stateQ;
  logState_t  stateNext;
  logIdx_t    cntQ;
  logIdx_t    cntNext;
  timestamp_t tsQ;
  logic       accept;

  // A beat is logged only while active and not clearing
  assign accept = axiValid && axiReady && (stateQ == LogActive) && !clear;

  // Write straight into the current slot on the accepting edge
  assign wrEn    = accept;
  assign wrIdx   = cntQ;
  assign wrEntry = {tsQ, axiAddr, {PadW{1'b0}}, axiLen, axiId};

  assign full = (stateQ == LogFull);

  // State and slot counter
  always_comb begin
    stateNext = stateQ;
    cntNext   = cntQ;
    if (clear) begin
      stateNext = LogActive;
      cntNext   = '0;
    end else if (accept) begin
      if (cntQ == LastIdx) begin
        // Counter parks on the last slot
        stateNext = LogFull;
      end else begin
        cntNext = cntQ + 1'b1;
      end
    end
  end

  always_ff @(posedge Clk_CI or negedge rstN) begin
    if (!rstN) begin
      stateQ <= LogActive;
      cntQ   <= '0;
    end else begin
      stateQ <= stateNext;
      cntQ   <= cntNext;
    end
  end

  // Timestamp restarts on clear, otherwise counts every cycle
  always_ff @(posedge Clk_CI or negedge rstN) begin
    if (!rstN) begin
      tsQ <= '0;
    end else if (clear) begin
      tsQ <= '0;
    end else begin
      tsQ <= tsQ + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/logMemory.sv
// ******************************
// Log entry memory
// Simple dual-port RAM, synchronous
// write on port A, registered read
// on port B
// ******************************

`timescale 1ns/10ps
`default_nettype none

`include "axiLog_consts.svh"

module logMemory (
  input  logic                 Clk_CI,

  // Port A, write
  input  logic                 wrEn,
  input  axiLogPkg::logIdx_t   wrIdx,
  input  axiLogPkg::logEntry_t wrEntry,

  // Port B, read
  input  logic                 rdEnMem,
  input  axiLogPkg::logIdx_t   rdIdx,
  output axiLogPkg::logEntry_t memEntry
);

  import axiLogPkg::*;

  logEntry_t mem [`LOG_DEPTH];

  // Port A
  always_ff @(posedge Clk_CI) begin
    if (wrEn) begin
      mem[wrIdx] <= wrEntry;
    end
  end

  // Port B, read-first so a same-cycle write shows the old entry
  always_ff @(posedge Clk_CI) begin
    if (rdEnMem) begin
      memEntry <= mem[rdIdx];
    end
  end

endmodule

`default_nettype wire

// File: rtl/logReadout.sv
// ******************************
// Log readout
// Maps 32-bit word reads onto entry
// reads and returns the selected word
// two cycles later
// ******************************

`timescale 1ns/10ps
`default_nettype none

`include "axiLog_consts.svh"

module logReadout (
  input  logic                 Clk_CI,
  input  logic                 rstN,

  // Word read request
  input  logic                 rdEn,
  input  axiLogPkg::rdAddr_t   rdAddr,

  // Memory read port
  output logic                 rdEnMem,
  output axiLogPkg::logIdx_t   rdIdx,
  input  axiLogPkg::logEntry_t memEntry,

  // Word response
  output axiLogPkg::rdData_t   rdData,
  output logic                 rdValid
);

  import axiLogPkg::*;

  logic [1:0] wordSel;
  logic [1:0] wordSelQ;
  logic       rdEnQ;
  rdData_t    wordMux;

  // Upper address bits pick the entry, bits 3 and 2 the word
  assign rdEnMem = rdEn;
  assign rdIdx   = rdAddr[`RD_ADDR_W-1:4];
  assign wordSel = rdAddr[3:2];

  // Strobe pipeline
  always_ff @(posedge Clk_CI or negedge rstN) begin
    if (!rstN) begin
      rdEnQ   <= 1'b0;
      rdValid <= 1'b0;
    end else begin
      rdEnQ   <= rdEn;
      rdValid <= rdEnQ;
    end
  end

  // Word select travels with the memory read
  always_ff @(posedge Clk_CI) begin
    wordSelQ <= wordSel;
  end

  always_comb begin
    case (wordSelQ)
      2'd0:    wordMux = memEntry[`RD_DATA_W-1:0];
      2'd1:    wordMux = memEntry[2*`RD_DATA_W-1:`RD_DATA_W];
      2'd2:    wordMux = memEntry[3*`RD_DATA_W-1:2*`RD_DATA_W];
      // No fourth word in an entry
      default: wordMux = '0;
    endcase
  end

  always_ff @(posedge Clk_CI) begin
    if (rdEnQ) begin
      rdData <= wordMux;
    end
  end

endmodule

`default_nettype wire

// File: testbench/axiLoggerTb.sv
// ******************************
// AXI logger testbench
// Random address channel traffic
// against a logging model, with word
// readback and latency checks
// ******************************

`timescale 1ns/10ps
`default_nettype none

`include "axiLog_consts.svh"

module axiLoggerTb;

  import axiLogPkg::*;

  localparam int ClkPeriod     = 40;
  localparam int T1Cycles      = 80;
  localparam int T2Cycles      = 40;
  localparam int T3MaxCycles   = 600;
  localparam int T3ExtraCycles = 30;
  localparam int T4MaxCycles   = 200;
  localparam int T5Reads       = 24;
  localparam int StimCycles    = 2 + T1Cycles + T2Cycles + T3MaxCycles + T3ExtraCycles
                                 + 5 + T4MaxCycles;
  // Four full readbacks plus the random reads, each with a short drain
  localparam int ReadCycles    = 4 * (`LOG_DEPTH * 3 + 10) + T5Reads + 10;

  logic     Clk_CI = 1'b0;
  logic     rstN;
  logic     axiValid;
  logic     axiReady;
  axiId_t   axiId;
  axiAddr_t axiAddr;
  axiLen_t  axiLen;
  logic     clear;
  logic     full;
  logic     rdEn;
  rdAddr_t  rdAddr;
  rdData_t  rdData;
  logic     rdValid;

  // Model of the log contents, never erased by clear
  axiId_t     modelId   [`LOG_DEPTH];
  axiAddr_t   modelAddr [`LOG_DEPTH];
  axiLen_t    modelLen  [`LOG_DEPTH];
  timestamp_t modelTs   [`LOG_DEPTH];
  timestamp_t tsCount;
  int         modelCnt;
  logic       modelFull;

  // Outstanding reads, expected word and arrival cycle
  rdData_t expData  [$];
  int      expCycle [$];

  integer seed = 32'hb52e;
  int     cycleCnt = 0;
  int     errCount = 0;
  int     passCount = 0;
  int     failCount = 0;

  axiLogger axiLogger_inst (
    .Clk_CI   (Clk_CI),
    .rstN     (rstN),
    .axiValid (axiValid),
    .axiReady (axiReady),
    .axiId    (axiId),
    .axiAddr  (axiAddr),
    .axiLen   (axiLen),
    .clear    (clear),
    .full     (full),
    .rdEn     (rdEn),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .rdValid  (rdValid)
  );

  always #(ClkPeriod / 2) Clk_CI = ~Clk_CI;

  always @(posedge Clk_CI) begin
    cycleCnt <= cycleCnt + 1;
  end

  // Logging model, one update per rising edge
  always @(posedge Clk_CI or negedge rstN) begin
    if (!rstN) begin
      tsCount   = '0;
      modelCnt  = 0;
      modelFull = 1'b0;
    end else if (clear) begin
      tsCount   = '0;
      modelCnt  = 0;
      modelFull = 1'b0;
    end else begin
      if (axiValid && axiReady && !modelFull) begin
        modelId[modelCnt]   = axiId;
        modelAddr[modelCnt] = axiAddr;
        modelLen[modelCnt]  = axiLen;
        modelTs[modelCnt]   = tsCount;
        if (modelCnt == `LOG_DEPTH - 1) begin
          modelFull = 1'b1;
        end else begin
          modelCnt = modelCnt + 1;
        end
      end
      tsCount = tsCount + 1'b1;
    end
  end

  task automatic checkData(input rdData_t got, input rdData_t want);
    if (got !== want) begin
      $display("error %0t: rdData is %h, expected %h", $time, got, want);
      errCount++;
    end
  endtask

  task automatic checkFull(input logic got, input logic want);
    if (got !== want) begin
      $display("error %0t: full is %b, expected %b", $time, got, want);
      errCount++;
    end
  endtask

  // Word layout: 0 holds id and length, 1 the address, 2 the timestamp
  function automatic rdData_t expectedWord(input logIdx_t idx, input logic [1:0] word);
    rdData_t w;
    case (word)
      2'd0:    w = {{(`RD_DATA_W - `AXI_LEN_W - `AXI_ID_W){1'b0}}, modelLen[idx], modelId[idx]};
      2'd1:    w = modelAddr[idx];
      2'd2:    w = modelTs[idx];
      default: w = '0;
    endcase
    return w;
  endfunction

  // Wait for a falling edge and check the outputs settled there
  task automatic nextCycle();
    rdData_t wantData;
    int      wantCycle;
    @(negedge Clk_CI);
    checkFull(full, modelFull);
    if (rdValid) begin
      if (expData.size() == 0) begin
        $display("rdValid went high at %0t with no read outstanding", $time);
        errCount++;
      end else begin
        wantData  = expData.pop_front();
        wantCycle = expCycle.pop_front();
        if (wantCycle != cycleCnt) begin
          $display("rdValid came at cycle %0d but was due at cycle %0d", cycleCnt, wantCycle);
          errCount++;
        end
        checkData(rdData, wantData);
      end
    end else if (expCycle.size() > 0 && expCycle[0] <= cycleCnt) begin
      $display("rdValid missing, the read due at cycle %0d never returned", expCycle[0]);
      errCount++;
      void'(expData.pop_front());
      void'(expCycle.pop_front());
    end
  endtask

  task automatic idleBus();
    axiValid = 1'b0;
    axiReady = 1'b0;
    clear    = 1'b0;
    rdEn     = 1'b0;
  endtask

  task automatic randomTraffic();
    axiValid = $random(seed);
    axiReady = $random(seed);
    axiId    = $random(seed);
    axiAddr  = $random(seed);
    axiLen   = $random(seed);
    clear    = 1'b0;
    rdEn     = 1'b0;
  endtask

  // Low address bits are don't-care, so they get random values
  task automatic issueRead(input logIdx_t idx, input logic [1:0] word);
    logic [1:0] lowBits;
    lowBits = $random(seed);
    rdEn    = 1'b1;
    rdAddr  = {idx, word, lowBits};
    expData.push_back(expectedWord(idx, word));
    expCycle.push_back(cycleCnt + 2);
  endtask

  task automatic drainReads();
    nextCycle();
    rdEn = 1'b0;
    while (expData.size() > 0) begin
      nextCycle();
    end
  endtask

  // Back-to-back reads of whole entries
  task automatic readEntries(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      for (int w = 0; w < 3; w++) begin
        nextCycle();
        idleBus();
        issueRead(logIdx_t'(i), w[1:0]);
      end
    end
    drainReads();
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    if (errCount == errsBefore) begin
      $display("test %s: pass", name);
      passCount++;
    end else begin
      $display("test %s: fail, %0d errors", name, errCount - errsBefore);
      failCount++;
    end
  endtask

  // Watchdog
  initial begin
    #((StimCycles + ReadCycles + 100) * ClkPeriod);
    $display("timeout, the run did not finish in the expected number of cycles");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int errsBefore;
    int startIdx;
    int n;

    rstN     = 1'b0;
    axiId    = '0;
    axiAddr  = '0;
    axiLen   = '0;
    rdAddr   = '0;
    idleBus();
    repeat (2) @(posedge Clk_CI);
    @(negedge Clk_CI);
    rstN = 1'b1;

    // 1: random traffic, capped at 40 entries, full readback
    errsBefore = errCount;
    for (int c = 0; c < T1Cycles; c++) begin
      nextCycle();
      if (modelCnt < 40) begin
        randomTraffic();
      end else begin
        idleBus();
      end
    end
    // Let the last driven beat reach the model before counting entries
    nextCycle();
    idleBus();
    readEntries(0, modelCnt);
    finishTest("1 random logging", errsBefore);

    // 2: random valid and ready, new entries must follow in order
    errsBefore = errCount;
    startIdx   = modelCnt;
    for (int c = 0; c < T2Cycles; c++) begin
      nextCycle();
      if (modelCnt < 60) begin
        randomTraffic();
      end else begin
        idleBus();
      end
    end
    nextCycle();
    idleBus();
    readEntries(startIdx, modelCnt - startIdx);
    finishTest("2 handshake qualification", errsBefore);

    // 3: fill the log, then keep the bus busy
    errsBefore = errCount;
    n = 0;
    while (!modelFull && n < T3MaxCycles) begin
      nextCycle();
      randomTraffic();
      n++;
    end
    for (int c = 0; c < T3ExtraCycles; c++) begin
      nextCycle();
      randomTraffic();
    end
    nextCycle();
    idleBus();
    checkFull(full, 1'b1);
    readEntries(0, `LOG_DEPTH);
    finishTest("3 full log", errsBefore);

    // 4: clear with a handshake in the same cycle
    errsBefore = errCount;
    nextCycle();
    randomTraffic();
    axiValid = 1'b1;
    axiReady = 1'b1;
    clear    = 1'b1;
    nextCycle();
    idleBus();
    checkFull(full, 1'b0);
    n = 0;
    while (modelCnt < 5 && n < T4MaxCycles) begin
      nextCycle();
      randomTraffic();
      n++;
    end
    readEntries(0, `LOG_DEPTH);
    finishTest("4 clear under traffic", errsBefore);

    // 5: random back-to-back word reads, every fourth one of word 3
    errsBefore = errCount;
    for (int r = 0; r < T5Reads; r++) begin
      nextCycle();
      idleBus();
      if (r % 4 == 3) begin
        issueRead(logIdx_t'($random(seed)), 2'd3);
      end else begin
        issueRead(logIdx_t'($random(seed)), 2'($unsigned(r % 3)));
      end
    end
    drainReads();
    finishTest("5 read latency and word 3", errsBefore);

    $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
